// ==== verilog/strand_params.svh ====
// ################################################
// Sizing of the strand selection stage. The issue
// strand index field is 2 bits, so STRANDS max 4.
// ################################################

`ifndef STRAND_PARAMS_SVH
`define STRAND_PARAMS_SVH

// Hardware threads sharing the pipeline
`define STRANDS 4

// Vector lanes stepped by a strided memory instruction
`define LANES 16

// Issue to writeback for a long instruction, short ones take 1
`define LONG_LATENCY 4

// All-zero word decodes as the NOP class
`define NOP_WORD 32'h0000_0000

`endif

// ==== verilog/isa_pkg.sv ====
// ################################################
// Instruction word layout and class decode.
// Reserved class codes 6 and 7 decode as SHORT_ALU.
// ################################################

`default_nettype none

package isa_pkg;

	// Class lives in the top 3 bits of the word
	typedef enum logic [2:0] {
		NOP_OP      = 3'd0,
		SHORT_ALU   = 3'd1,
		LONG_ALU    = 3'd2,
		SCALAR_MEM  = 3'd3,
		STRIDED_MEM = 3'd4,
		BRANCH      = 3'd5
	} op_class_e;

	// For STRIDED_MEM the low 8 bits of imm hold the stride
	typedef struct packed {
		logic [2:0]  op_class;
		logic [4:0]  dest;
		logic [4:0]  src_a;
		logic [4:0]  src_b;
		logic [13:0] imm;
	} instruction_t;

	function automatic op_class_e op_class_of(instruction_t instr);
		op_class_e cls;
		if (instr.op_class > 3'd5)
			cls = SHORT_ALU;
		else
			cls = op_class_e'(instr.op_class);
		return cls;
	endfunction

	function automatic logic is_long_latency(instruction_t instr);
		op_class_e cls;
		cls = op_class_of(instr);
		return (cls == LONG_ALU) || (cls == SCALAR_MEM);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/strand_pkg.sv ====
// ################################################
// Strand control types shared by the selection
// stage. Strand index is fixed at 2 bits.
// ################################################

`default_nettype none

package strand_pkg;
	import isa_pkg::*;

	typedef enum logic [1:0] {
		WAIT_FETCH = 2'd0,
		READY      = 2'd1,
		LANE_LOOP  = 2'd2,
		SUSPENDED  = 2'd3
	} strand_state_e;

	// Held by the fetch unit until the strand requests the next one
	typedef struct packed {
		instruction_t instruction;
		logic         valid;
		logic [31:0]  pc;
		logic         branch_predicted;
	} fetch_slot_t;

	// Single cycle pulses, lane and offset valid with them
	typedef struct packed {
		logic        rollback;
		logic        retry;
		logic        suspend;
		logic        resume;
		logic [3:0]  lane;
		logic [31:0] strided_offset;
	} rollback_t;

	typedef struct packed {
		logic [31:0]  pc;
		instruction_t instruction;
		logic [3:0]   reg_lane;
		logic [31:0]  strided_offset;
		logic [1:0]   strand;
		logic         branch_predicted;
	} issue_t;

endpackage

`default_nettype wire

// ==== verilog/strand_fsm.sv ====
// ################################################
// Control FSM of one strand. Rollback wins over
// suspend, suspend over retry, retry over a grant.
// ################################################

`default_nettype none

`include "strand_params.svh"

module strand_fsm
	import isa_pkg::*;
	import strand_pkg::*;
(
	input wire logic   clk,
	input wire logic   reset,
	input var fetch_slot_t fetch_i,
	input var rollback_t   rollback_i,
	input wire logic   grant_i,
	output logic       ready_o,
	output logic       next_instruction_o,
	output logic [3:0] reg_lane_o,
	output logic [31:0] strided_offset_o
);
	localparam logic [3:0] FIRST_LANE = 4'(`LANES - 1);

	strand_state_e state_q;
	strand_state_e state_d;
	logic [3:0]    lane_q;
	logic [3:0]    lane_d;
	logic [31:0]   offset_q;
	logic [31:0]   offset_d;
	logic          is_strided;
	logic          last_lane;
	logic          redirect;
	logic          done;

	assign is_strided = op_class_of(fetch_i.instruction) == STRIDED_MEM;
	assign last_lane = lane_q == 4'd0;
	assign redirect = rollback_i.rollback | rollback_i.retry | rollback_i.suspend;

	// Only a held slot may be offered to the arbiter
	assign ready_o = ((state_q == READY) || (state_q == LANE_LOOP)) && fetch_i.valid;

	// Last issue of the current instruction
	assign done = grant_i && (!is_strided || last_lane);

	// A redirect in the same cycle keeps the slot for reissue
	assign next_instruction_o = done && !redirect;

	assign reg_lane_o = lane_q;
	assign strided_offset_o = offset_q;

	always_comb
	begin
		state_d = state_q;
		lane_d = lane_q;
		offset_d = offset_q;
		if (rollback_i.rollback)
		begin
			state_d = rollback_i.suspend ? SUSPENDED : WAIT_FETCH;
			lane_d = rollback_i.lane;
			offset_d = rollback_i.strided_offset;
		end
		else if (rollback_i.suspend)
			state_d = SUSPENDED;
		else if (rollback_i.retry)
		begin
			// Same slot goes out again at the given lane
			state_d = READY;
			lane_d = rollback_i.lane;
			offset_d = rollback_i.strided_offset;
		end
		else
		begin
			case (state_q)
				WAIT_FETCH:
					if (fetch_i.valid)
						state_d = READY;

				READY, LANE_LOOP:
					if (done)
					begin
						state_d = WAIT_FETCH;
						lane_d = FIRST_LANE;
						offset_d = 32'd0;
					end
					else if (grant_i)
					begin
						// Strided issue, step down one lane
						state_d = LANE_LOOP;
						lane_d = lane_q - 4'd1;
						offset_d = offset_q + 32'(fetch_i.instruction.imm[7:0]);
					end

				SUSPENDED:
					if (rollback_i.resume)
						state_d = READY;

				default:
					state_d = WAIT_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_q <= WAIT_FETCH;
			lane_q <= FIRST_LANE;
			offset_q <= 32'd0;
		end
		else
		begin
			state_q <= state_d;
			lane_q <= lane_d;
			offset_q <= offset_d;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/issue_arbiter.sv ====
// ################################################
// Round-robin arbiter with a one-hot grant. The
// grant is combinational from the requests.
// ################################################

`default_nettype none

`include "strand_params.svh"

module issue_arbiter #(
	parameter int WIDTH = `STRANDS
) (
	input wire logic              clk,
	input wire logic              reset,
	input wire logic [WIDTH-1:0]  request_i,
	output logic [WIDTH-1:0]      grant_oh_o
);
	logic [WIDTH-1:0] last_grant_q;
	logic [WIDTH-1:0] above_last;
	logic [WIDTH-1:0] masked_request;

	// Requesters strictly above the last winner go first
	assign above_last = ~((last_grant_q << 1) - WIDTH'(1));
	assign masked_request = request_i & above_last;

	// Lowest set bit of whichever request set applies
	always_comb
	begin
		if (|masked_request)
			grant_oh_o = masked_request & (~masked_request + WIDTH'(1));
		else
			grant_oh_o = request_i & (~request_i + WIDTH'(1));
	end

	// Start as if the top requester won, so bit 0 leads
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			last_grant_q <= WIDTH'(1) << (WIDTH - 1);
		else if (|grant_oh_o)
			last_grant_q <= grant_oh_o;
	end

endmodule

`default_nettype wire

// ==== verilog/execute_hazard_detect.sv ====
// ################################################
// Writeback conflict check. Anything not long
// latency counts as a 1 cycle instruction.
// ################################################

`default_nettype none

`include "strand_params.svh"

module execute_hazard_detect
	import isa_pkg::*;
	import strand_pkg::*;
(
	input wire logic                 clk,
	input wire logic                 reset,
	input var fetch_slot_t           fetch_i [`STRANDS],
	input wire logic [`STRANDS-1:0]  grant_oh_i,
	output logic [`STRANDS-1:0]      block_o
);
	localparam int DEPTH = `LONG_LATENCY - 1;

	logic [`STRANDS-1:0] pending_long;
	logic                long_granted;
	logic [DEPTH-1:0]    long_issued_q;

	always_comb
	begin
		for (int n = 0; n < `STRANDS; n++)
			pending_long[n] = is_long_latency(fetch_i[n].instruction);
	end

	// Grant is one-hot, so this is the winner's class
	assign long_granted = |(grant_oh_i & pending_long);

	// Bit k set means a long issue k+1 cycles ago
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			long_issued_q <= '0;
		else if (DEPTH > 1)
			long_issued_q <= {long_issued_q[DEPTH-2:0], long_granted};
		else
			long_issued_q <= DEPTH'(long_granted);
	end

	// The top bit matures at the next edge
	// A short issue then would share the writeback slot
	assign block_o = {`STRANDS{long_issued_q[DEPTH-1]}} & ~pending_long;

endmodule

`default_nettype wire

// ==== verilog/strand_select_stage.sv ====
// ################################################
// Strand selection stage. Fetch slots must be held
// until their request pulse; no back-pressure.
// ################################################

`default_nettype none

`include "strand_params.svh"

module strand_select_stage
	import isa_pkg::*;
	import strand_pkg::*;
(
	input wire logic                 clk,
	input wire logic                 reset,
	input wire logic [`STRANDS-1:0]  strand_enable_i,
	input var fetch_slot_t           fetch_i [`STRANDS],
	input var rollback_t             rollback_i [`STRANDS],
	output logic [`STRANDS-1:0]      instruction_req_o,
	output issue_t                   issue_o
);
	logic [`STRANDS-1:0] strand_ready;
	logic [`STRANDS-1:0] hazard_block;
	logic [`STRANDS-1:0] eligible;
	logic [`STRANDS-1:0] grant_oh;
	logic [3:0]          reg_lane [`STRANDS];
	logic [31:0]         strided_offset [`STRANDS];
	logic [1:0]          grant_idx;

	for (genvar n = 0; n < `STRANDS; n++)
	begin : g_strand
		strand_fsm strand_fsm_inst (
			.clk                (clk),
			.reset              (reset),
			.fetch_i            (fetch_i[n]),
			.rollback_i         (rollback_i[n]),
			.grant_i            (grant_oh[n]),
			.ready_o            (strand_ready[n]),
			.next_instruction_o (instruction_req_o[n]),
			.reg_lane_o         (reg_lane[n]),
			.strided_offset_o   (strided_offset[n])
		);
	end

	execute_hazard_detect hazard_inst (
		.clk        (clk),
		.reset      (reset),
		.fetch_i    (fetch_i),
		.grant_oh_i (grant_oh),
		.block_o    (hazard_block)
	);

	// Disabled or conflicting strands sit out this round
	assign eligible = strand_ready & strand_enable_i & ~hazard_block;

	issue_arbiter #(
		.WIDTH (`STRANDS)
	) arbiter_inst (
		.clk        (clk),
		.reset      (reset),
		.request_i  (eligible),
		.grant_oh_o (grant_oh)
	);

	// One-hot to index
	always_comb
	begin
		grant_idx = 2'd0;
		for (int n = 0; n < `STRANDS; n++)
			if (grant_oh[n])
				grant_idx = 2'(n);
	end

	// Issue register, loaded at the grant edge
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			issue_o <= '0;
		else if (|grant_oh)
		begin
			issue_o.pc <= fetch_i[grant_idx].pc;
			issue_o.instruction <= fetch_i[grant_idx].instruction;
			issue_o.branch_predicted <= fetch_i[grant_idx].branch_predicted;
			issue_o.reg_lane <= reg_lane[grant_idx];
			issue_o.strided_offset <= strided_offset[grant_idx];
			issue_o.strand <= grant_idx;
		end
		else
		begin
			// Bubble, strand and lane fields hold
			issue_o.pc <= 32'd0;
			issue_o.instruction <= `NOP_WORD;
			issue_o.branch_predicted <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tb/strand_select_asserts.sv ====
// ################################################
// Checks for the strand selection stage. Lane and
// retry models assume no overlapping redirects.
// ################################################

`default_nettype none

`include "strand_params.svh"

module strand_select_asserts
	import isa_pkg::*;
	import strand_pkg::*;
(
	input wire logic                clk,
	input wire logic                reset,
	input wire logic [`STRANDS-1:0] strand_enable_i,
	input var fetch_slot_t          fetch_i [`STRANDS],
	input var rollback_t            rollback_i [`STRANDS],
	input wire logic [`STRANDS-1:0] instruction_req_o,
	input var issue_t               issue_o,
	input wire logic [`STRANDS-1:0] grant_oh,
	input wire logic [`STRANDS-1:0] eligible
);
	timeunit 1ns;
	timeprecision 100ps;

	fetch_slot_t         fetch_q [`STRANDS];
	issue_t              issue_q;
	logic [`STRANDS-1:0] enable_q;
	logic [`STRANDS-1:0] susp;
	logic [`STRANDS-1:0] susp_q;
	logic [3:0]          lane_m [`STRANDS];
	logic [31:0]         off_m [`STRANDS];
	logic [3:0]          exp_lane_q;
	logic [31:0]         exp_off_q;
	logic [31:0]         retry_pc [`STRANDS];
	logic [`STRANDS-1:0] retry_wait;
	logic [`STRANDS-1:0] retry_check;
	logic [2:0]          passed_over [`STRANDS];
	logic [`STRANDS-1:0] starved;
	logic [1:0]          gidx;
	logic                live;
	logic                live_long;
	logic                live_strided;
	int                  error_count = 0;

	// Long latency classes write back `LONG_LATENCY cycles after issue
	assign live = issue_o.instruction != `NOP_WORD;
	assign live_long = live && (issue_o.instruction.op_class == 3'd2 ||
		issue_o.instruction.op_class == 3'd3);
	assign live_strided = live && issue_o.instruction.op_class == 3'd4;

	always_comb
	begin
		gidx = 2'd0;
		for (int n = 0; n < `STRANDS; n++)
			if (grant_oh[n])
				gidx = 2'(n);
	end

	// Still eligible after four grants to other strands
	always_comb
	begin
		for (int n = 0; n < `STRANDS; n++)
			starved[n] = passed_over[n] >= 3'd4;
	end

	// Reference model of each strand's lane and offset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			issue_q <= '0;
			enable_q <= '0;
			susp <= '0;
			susp_q <= '0;
			retry_wait <= '0;
			retry_check <= '0;
			exp_lane_q <= 4'd15;
			exp_off_q <= '0;
			for (int n = 0; n < `STRANDS; n++)
			begin
				fetch_q[n] <= '0;
				lane_m[n] <= 4'd15;
				off_m[n] <= '0;
				retry_pc[n] <= '0;
				passed_over[n] <= '0;
			end
		end
		else
		begin
			issue_q <= issue_o;
			enable_q <= strand_enable_i;
			susp_q <= susp;
			exp_lane_q <= lane_m[gidx];
			exp_off_q <= off_m[gidx];
			for (int n = 0; n < `STRANDS; n++)
			begin
				fetch_q[n] <= fetch_i[n];
				if (rollback_i[n].suspend)
					susp[n] <= 1'b1;
				else if (rollback_i[n].resume)
					susp[n] <= 1'b0;
				// A suspend drops a grant in the same cycle, the lane replays
				if (rollback_i[n].rollback || rollback_i[n].retry)
				begin
					lane_m[n] <= rollback_i[n].lane;
					off_m[n] <= rollback_i[n].strided_offset;
				end
				else if (grant_oh[n] && !rollback_i[n].suspend &&
					fetch_i[n].instruction.op_class == 3'd4 && lane_m[n] != 4'd0)
				begin
					lane_m[n] <= lane_m[n] - 4'd1;
					off_m[n] <= off_m[n] + 32'(fetch_i[n].instruction.imm[7:0]);
				end
				else if (grant_oh[n] && !rollback_i[n].suspend)
				begin
					lane_m[n] <= 4'd15;
					off_m[n] <= '0;
				end
				if (rollback_i[n].retry && fetch_i[n].valid)
				begin
					retry_wait[n] <= 1'b1;
					retry_pc[n] <= fetch_i[n].pc;
				end
				else if (grant_oh[n])
					retry_wait[n] <= 1'b0;
				// First grant after the retry cycle must carry the retried slot
				retry_check[n] <= retry_wait[n] && grant_oh[n] && !rollback_i[n].retry;
				if (!eligible[n] || grant_oh[n])
					passed_over[n] <= '0;
				else if (|grant_oh)
					passed_over[n] <= passed_over[n] + 3'd1;
			end
		end
	end

	a_reset: assert property (@(posedge clk) (reset || $past(reset)) |->
		(issue_o == '0 && instruction_req_o == '0))
		else begin
			$error("FAILED issue_o got %h instruction_req_o got %h during reset, exp 0",
				issue_o, instruction_req_o);
			error_count++;
		end
	a_pc: assert property (@(posedge clk) disable iff (reset) live |->
		(fetch_q[issue_o.strand].valid && issue_o.pc == fetch_q[issue_o.strand].pc))
		else begin
			$error("FAILED issue_o.pc exp %h got %h", fetch_q[issue_o.strand].pc, issue_o.pc);
			error_count++;
		end
	a_instr: assert property (@(posedge clk) disable iff (reset) live |->
		issue_o.instruction == fetch_q[issue_o.strand].instruction)
		else begin
			$error("FAILED issue_o.instruction exp %h got %h",
				fetch_q[issue_o.strand].instruction, issue_o.instruction);
			error_count++;
		end
	a_branch: assert property (@(posedge clk) disable iff (reset) live |->
		issue_o.branch_predicted == fetch_q[issue_o.strand].branch_predicted)
		else begin
			$error("FAILED issue_o.branch_predicted exp %h got %h",
				fetch_q[issue_o.strand].branch_predicted, issue_o.branch_predicted);
			error_count++;
		end
	a_bubble: assert property (@(posedge clk) disable iff (reset) !live |->
		(issue_o.pc == '0 && !issue_o.branch_predicted &&
		issue_o.strand == issue_q.strand && issue_o.reg_lane == issue_q.reg_lane &&
		issue_o.strided_offset == issue_q.strided_offset))
		else begin
			$error("FAILED issue_o bubble got %h, held fields from %h", issue_o, issue_q);
			error_count++;
		end
	a_enable: assert property (@(posedge clk) disable iff (reset) live |->
		enable_q[issue_o.strand])
		else begin $error("Issue came from a disabled strand"); error_count++; end
	a_fair: assert property (@(posedge clk) disable iff (reset)
		(grant_oh != '0 && grant_oh == $past(grant_oh)) |->
		((eligible & $past(eligible) & ~grant_oh) == '0))
		else begin $error("Strand granted twice while another waited"); error_count++; end
	a_window: assert property (@(posedge clk) disable iff (reset) starved == '0)
		else begin
			$error("Eligible strand passed over by four grants in a row, mask %h", starved);
			error_count++;
		end
	a_lane: assert property (@(posedge clk) disable iff (reset) live_strided |->
		issue_o.reg_lane == exp_lane_q)
		else begin
			$error("FAILED issue_o.reg_lane exp %h got %h", exp_lane_q, issue_o.reg_lane);
			error_count++;
		end
	a_offset: assert property (@(posedge clk) disable iff (reset) live_strided |->
		issue_o.strided_offset == exp_off_q)
		else begin
			$error("FAILED issue_o.strided_offset exp %h got %h",
				exp_off_q, issue_o.strided_offset);
			error_count++;
		end
	a_hazard: assert property (@(posedge clk) disable iff (reset) (live && !live_long) |->
		!$past(live_long, `LONG_LATENCY - 1))
		else begin $error("Short issue collides at writeback"); error_count++; end
	a_suspend: assert property (@(posedge clk) disable iff (reset) live |->
		!susp_q[issue_o.strand])
		else begin $error("Suspended strand issued"); error_count++; end
	a_retry: assert property (@(posedge clk) disable iff (reset)
		(live && retry_check[issue_o.strand]) |-> issue_o.pc == retry_pc[issue_o.strand])
		else begin
			$error("FAILED issue_o.pc exp %h got %h after retry",
				retry_pc[issue_o.strand], issue_o.pc);
			error_count++;
		end

endmodule

bind strand_select_stage strand_select_asserts asserts_inst (
	.clk               (clk),
	.reset             (reset),
	.strand_enable_i   (strand_enable_i),
	.fetch_i           (fetch_i),
	.rollback_i        (rollback_i),
	.instruction_req_o (instruction_req_o),
	.issue_o           (issue_o),
	.grant_oh          (grant_oh),
	.eligible          (eligible)
);

`default_nettype wire

// ==== tb/strand_select_tb.sv ====
// ################################################
// Random fetch traffic with suspend, rollback and
// retry events; checks live in the bound asserts.
// ################################################

`default_nettype none

`include "strand_params.svh"

module strand_select_tb
	import isa_pkg::*;
	import strand_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLES = 1200;

	logic                clk;
	logic                reset;
	logic [`STRANDS-1:0] enable;
	logic [`STRANDS-1:0] req;
	logic [`STRANDS-1:0] req_seen;
	fetch_slot_t         fetch [`STRANDS];
	rollback_t           rollback [`STRANDS];
	issue_t              issue;
	logic [15:0]         lfsr;
	logic [31:0]         pc [`STRANDS];
	int                  wait_cnt [`STRANDS];

	strand_select_stage dut0 (
		.clk               (clk),
		.reset             (reset),
		.strand_enable_i   (enable),
		.fetch_i           (fetch),
		.rollback_i        (rollback),
		.instruction_req_o (req),
		.issue_o           (issue)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// New slot with a random class, never the NOP class
	task automatic refill_slot(input int s);
		logic [15:0]  r;
		instruction_t ins;
		op_class_e    cls;
		draw_bits(3, r);
		cls = op_class_e'(3'((r % 5) + 1));
		draw_bits(8, r);
		ins = '0;
		ins.op_class = cls;
		ins.dest = r[4:0];
		ins.src_a = r[7:3];
		ins.imm = {6'd0, r[7:0] | 8'd1};
		pc[s] = pc[s] + 32'd4;
		fetch[s] = '{instruction: ins, valid: 1'b1, pc: pc[s],
			branch_predicted: cls == BRANCH};
	endtask

	task automatic drive_cycle(input int cyc);
		logic [15:0] r;
		int          a;
		a = (cyc / 50) % `STRANDS;
		draw_bits(4, r);
		// Disabled window, then a random mask
		if (cyc >= 300 && cyc < 330)
			enable = '0;
		else if (cyc >= 330 && cyc < 420)
			enable = r[3:0];
		else
			enable = '1;
		for (int s = 0; s < `STRANDS; s++)
		begin
			rollback[s] = '0;
			if (req_seen[s])
			begin
				fetch[s].valid = 1'b0;
				draw_bits(2, r);
				wait_cnt[s] = r % 3;
				// Zero wait puts the next slot up one cycle after the request
				if (wait_cnt[s] == 0)
					refill_slot(s);
			end
			else if (!fetch[s].valid)
			begin
				wait_cnt[s]--;
				if (wait_cnt[s] == 0)
					refill_slot(s);
			end
		end
		draw_bits(16, r);
		case (cyc % 50)
			10: rollback[a].suspend = 1'b1;
			22: rollback[a].resume = 1'b1;
			30: rollback[(a + 1) % 4] = '{rollback: 1'b1, lane: r[3:0],
				strided_offset: {16'd0, r}, default: '0};
			40: if (fetch[(a + 2) % 4].valid)
				rollback[(a + 2) % 4] = '{retry: 1'b1, lane: r[7:4],
					strided_offset: {20'd0, r[11:0]}, default: '0};
			default: ;
		endcase
	endtask

	initial
	begin
		reset = 1'b1;
		enable = '0;
		req_seen = '0;
		lfsr = 16'd54;
		for (int s = 0; s < `STRANDS; s++)
		begin
			fetch[s] = '0;
			rollback[s] = '0;
			pc[s] = 32'(s) << 16;
			wait_cnt[s] = s + 1;
		end
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		for (int cyc = 0; cyc < CYCLES; cyc++)
		begin
			@(negedge clk);
			req_seen = req;
			@(posedge clk);
			#1;
			drive_cycle(cyc);
		end
		repeat (4) @(posedge clk);
		if (dut0.asserts_inst.error_count != 0)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "Assertion failures at the end of the run");
		end
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	// Stop at the first assertion failure
	always @(negedge clk)
	begin
		if (dut0.asserts_inst.error_count != 0)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "Assertion failure reported");
		end
	end

	initial
	begin
		#(CYCLES * 20 + 500);
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired before the stimulus finished");
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/strand_pkg.sv
verilog/strand_fsm.sv
verilog/issue_arbiter.sv
verilog/execute_hazard_detect.sv
verilog/strand_select_stage.sv
tb/strand_select_asserts.sv
tb/strand_select_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the strand selection testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module strand_select_tb -o strand_select_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/strand_select_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0
